//--- verilog.f
design/fu_pkg.sv
design/cdb_pkg.sv
design/fu_result_if.sv
design/alu_lane.sv
design/mult_lane.sv
design/complete_arbiter.sv
design/exec_complete.sv
verif/exec_complete_tb.sv

//--- Bender.yml
package:
  name: exec_complete

dependencies: {}

sources:
  # packages first, then interface, lanes, arbiter, top
  - design/fu_pkg.sv
  - design/cdb_pkg.sv
  - design/fu_result_if.sv
  - design/alu_lane.sv
  - design/mult_lane.sv
  - design/complete_arbiter.sv
  - design/exec_complete.sv
  - target: test
    files:
      - verif/exec_complete_tb.sv

//--- verif/exec_complete_tb.sv
// default MULT_BITS only; tags come from the entry index, so at most 64 entries; stops at first error
module exec_complete_tb import fu_pkg::*, cdb_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_tags        = 1 << tag_width;
  localparam int num_random      = 24;
  // cycles allowed for one ack edge, covers a full multiply
  localparam int ack_timeout     = 40;
  localparam int drain_timeout   = 100;
  // alu acks this close after a multiply ack must finish first
  localparam int overtake_window = 6;

  typedef struct {
    lane_t   lane;
    alu_op_t op;
    word_t   a;
    word_t   b;
    tag_t    tag;
  } entry_t;

  logic    clock;
  logic    reset;
  logic    alu_req;
  alu_op_t alu_op;
  word_t   alu_a;
  word_t   alu_b;
  tag_t    alu_tag;
  logic    alu_ack;
  logic    mult_req;
  word_t   mult_a;
  word_t   mult_b;
  tag_t    mult_tag;
  logic    mult_ack;
  logic    cdb_valid;
  tag_t    cdb_tag;
  word_t   cdb_value;

  // stimulus table and per-tag bookkeeping
  entry_t  stim[$];
  integer  seed;
  int      cycle_count = 0;
  int      results_seen = 0;
  logic    issued [num_tags] = '{default: 1'b0};
  logic    seen [num_tags] = '{default: 1'b0};
  word_t   exp_value [num_tags];
  int      ack_cycle [num_tags];
  int      bus_cycle [num_tags];

  exec_complete u_exec_complete (
    .clock     (clock),
    .reset     (reset),
    .alu_req   (alu_req),
    .alu_op    (alu_op),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_tag   (alu_tag),
    .alu_ack   (alu_ack),
    .mult_req  (mult_req),
    .mult_a    (mult_a),
    .mult_b    (mult_b),
    .mult_tag  (mult_tag),
    .mult_ack  (mult_ack),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value)
  );

  // 100 ns period
  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // rising-edge count, read only on falling edges
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  function automatic void add_entry(input lane_t lane, input alu_op_t op, input word_t a,
                                    input word_t b);
    entry_t e;
    e.lane = lane;
    e.op   = op;
    e.a    = a;
    e.b    = b;
    // index doubles as the unique tag
    e.tag  = tag_t'(stim.size());
    stim.push_back(e);
  endfunction

  task automatic build_table();
    int unsigned pick;
    word_t       a;
    word_t       b;
    alu_op_t     op;
    // alu corners, sub wrap and both compare outcomes
    add_entry(lane_alu, alu_add, 64'd5, 64'd7);
    add_entry(lane_alu, alu_sub, 64'd0, 64'd1);
    add_entry(lane_alu, alu_sub, 64'h8000_0000_0000_0000, 64'd1);
    add_entry(lane_alu, alu_and, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00);
    add_entry(lane_alu, alu_or, 64'hf0f0_f0f0_0000_0000, 64'h0000_ffff_0f0f_0000);
    add_entry(lane_alu, alu_xor, 64'haaaa_5555_aaaa_5555, 64'hffff_ffff_0000_0000);
    add_entry(lane_alu, alu_cmpeq, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0);
    add_entry(lane_alu, alu_cmpeq, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def1);
    // unused opcode runs as add
    add_entry(lane_alu, alu_op_t'(3'd6), 64'hffff_ffff_ffff_fff0, 64'h20);
    // multiplier corners, zero, one, all ones
    add_entry(lane_mult, alu_add, 64'd0, 64'hdead_beef);
    add_entry(lane_mult, alu_add, 64'd1, 64'h0123_4567_89ab_cdef);
    add_entry(lane_mult, alu_add, '1, '1);
    add_entry(lane_mult, alu_add, '1, 64'd2);
    // overtakes the multiply above
    add_entry(lane_alu, alu_add, 64'd100, 64'd23);
    // carries across digits, then back to back
    add_entry(lane_mult, alu_add, 64'h1_0000_0001, 64'hffff_ffff);
    add_entry(lane_mult, alu_add, 64'hdead_beef_cafe_f00d, 64'h1234_5678_9abc_def0);
    add_entry(lane_alu, alu_xor, 64'h0f0f, 64'hffff);
    add_entry(lane_alu, alu_and, 64'h0f0f, 64'hffff);
    // random mix of both lanes
    repeat (num_random) begin
      pick = $unsigned($random(seed));
      a    = {$random(seed), $random(seed)};
      b    = {$random(seed), $random(seed)};
      op   = alu_op_t'(3'(pick[6:4] % 6));
      // some compares with equal operands
      if (op == alu_cmpeq && pick[8]) begin
        b = a;
      end
      add_entry(lane_t'(pick[0]), op, a, b);
    end
  endtask

  // result by the operation rules, keyed later by tag
  function automatic word_t expected_value(input entry_t e);
    logic [2*word_width-1:0] full;
    word_t                   r;
    if (e.lane == lane_mult) begin
      // low half of the full product
      full = {{word_width{1'b0}}, e.a} * {{word_width{1'b0}}, e.b};
      r    = full[word_width-1:0];
    end else begin
      case (e.op)
        alu_sub:   r = e.a - e.b;
        alu_and:   r = e.a & e.b;
        alu_or:    r = e.a | e.b;
        alu_xor:   r = e.a ^ e.b;
        alu_cmpeq: r = (e.a == e.b) ? 64'd1 : 64'd0;
        default:   r = e.a + e.b;
      endcase
    end
    return r;
  endfunction

  //////////////////////////////
  // four-phase drivers
  //////////////////////////////

  // polls on falling edges until the lane's ack reaches level
  task automatic wait_ack(input lane_t lane, input logic level, input tag_t tag);
    int waited;
    waited = 0;
    while (((lane == lane_mult) ? mult_ack : alu_ack) !== level) begin
      @(negedge clock);
      waited++;
      if (waited > ack_timeout) begin
        $display("timeout at %0d ns: %s ack for tag %0d did not go %0d within %0d cycles",
                 $time, lane.name(), tag, level, ack_timeout);
        stop_with_failure();
      end
    end
  endtask

  // entered and left on a falling edge
  task automatic issue_entry(input entry_t e);
    issued[e.tag]    = 1'b1;
    exp_value[e.tag] = expected_value(e);
    if (e.lane == lane_mult) begin
      mult_a   = e.a;
      mult_b   = e.b;
      mult_tag = e.tag;
      mult_req = 1'b1;
    end else begin
      alu_op  = e.op;
      alu_a   = e.a;
      alu_b   = e.b;
      alu_tag = e.tag;
      alu_req = 1'b1;
    end
    wait_ack(e.lane, 1'b1, e.tag);
    ack_cycle[e.tag] = cycle_count;
    if (e.lane == lane_mult) begin
      mult_req = 1'b0;
    end else begin
      alu_req = 1'b0;
    end
    wait_ack(e.lane, 1'b0, e.tag);
  endtask

  //////////////////////////////
  // bus monitor
  //////////////////////////////

  // registered outputs are settled by the falling edge
  always @(negedge clock) begin
    if (reset === 1'b0 && cdb_valid === 1'b1) begin
      if (!issued[cdb_tag]) begin
        $display("error at %0d ns: bus carried tag %0d that was never issued", $time, cdb_tag);
        stop_with_failure();
      end else if (seen[cdb_tag]) begin
        $display("error at %0d ns: tag %0d reached the bus twice", $time, cdb_tag);
        stop_with_failure();
      end else begin
        check_value(cdb_value, exp_value[cdb_tag], $sformatf("bus value for tag %0d", cdb_tag));
        seen[cdb_tag]      = 1'b1;
        bus_cycle[cdb_tag] = cycle_count;
        results_seen++;
      end
    end
  end

  // an alu ack shortly after a multiply ack completes first
  task automatic check_ordering();
    int gap;
    int pairs;
    pairs = 0;
    foreach (stim[i]) begin
      if (stim[i].lane == lane_alu) begin
        foreach (stim[j]) begin
          if (stim[j].lane == lane_mult) begin
            gap = ack_cycle[stim[i].tag] - ack_cycle[stim[j].tag];
            if (gap > 0 && gap <= overtake_window) begin
              pairs++;
              check_value(word_t'(bus_cycle[stim[i].tag] < bus_cycle[stim[j].tag]), 64'd1,
                          $sformatf("alu tag %0d ahead of multiply tag %0d",
                                    stim[i].tag, stim[j].tag));
            end
          end
        end
      end
    end
    if (pairs == 0) begin
      $display("error: no alu request overlapped a running multiply");
      stop_with_failure();
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : main_sequence
    int waited;
    seed     = 47753;
    reset    = 1'b1;
    alu_req  = 1'b0;
    alu_op   = alu_add;
    alu_a    = '0;
    alu_b    = '0;
    alu_tag  = '0;
    mult_req = 1'b0;
    mult_a   = '0;
    mult_b   = '0;
    mult_tag = '0;
    build_table();
    // two reset cycles, released on a falling edge
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // quiet after reset with no req
    repeat (4) begin
      @(negedge clock);
      check_value(alu_ack, 64'd0, "alu_ack while idle");
      check_value(mult_ack, 64'd0, "mult_ack while idle");
      check_value(cdb_valid, 64'd0, "cdb_valid while idle");
    end
    foreach (stim[i]) begin
      issue_entry(stim[i]);
    end
    // drain the bus
    waited = 0;
    while (results_seen < stim.size()) begin
      @(negedge clock);
      waited++;
      if (waited > drain_timeout) begin
        $display("timeout at %0d ns: only %0d of %0d results reached the bus",
                 $time, results_seen, stim.size());
        stop_with_failure();
      end
    end
    // window for stray or repeated tags
    repeat (10) @(negedge clock);
    check_ordering();
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- design/exec_complete.sv
// execute-to-complete slice; each lane takes one four-phase request at a time, one bus result per cycle
module exec_complete import fu_pkg::*, cdb_pkg::*; #(
  // multiplier bits per cycle, must divide 64
  parameter int MULT_BITS = mult_bits_default
) (
  input  logic    clock,
  input  logic    reset,
  // alu issue port
  input  logic    alu_req,
  input  alu_op_t alu_op,
  input  word_t   alu_a,
  input  word_t   alu_b,
  input  tag_t    alu_tag,
  output logic    alu_ack,
  // multiplier issue port
  input  logic    mult_req,
  input  word_t   mult_a,
  input  word_t   mult_b,
  input  tag_t    mult_tag,
  output logic    mult_ack,
  // common data bus
  output logic    cdb_valid,
  output tag_t    cdb_tag,
  output word_t   cdb_value
);

  //////////////////////////////
  // lane result slots
  //////////////////////////////

  fu_result_if alu_res_if ();
  fu_result_if mult_res_if ();

  //////////////////////////////
  // execute lanes
  //////////////////////////////

  // single-cycle integer lane
  alu_lane u_alu_lane (
    .clock  (clock),
    .reset  (reset),
    .req    (alu_req),
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .tag    (alu_tag),
    .ack    (alu_ack),
    .result (alu_res_if.lane)
  );

  // multi-cycle lane, latency 64/MULT_BITS
  mult_lane #(
    .MULT_BITS (MULT_BITS)
  ) u_mult_lane (
    .clock  (clock),
    .reset  (reset),
    .req    (mult_req),
    .a      (mult_a),
    .b      (mult_b),
    .tag    (mult_tag),
    .ack    (mult_ack),
    .result (mult_res_if.lane)
  );

  //////////////////////////////
  // completion
  //////////////////////////////

  // picks one slot, registers the bus
  complete_arbiter u_complete_arbiter (
    .clock     (clock),
    .reset     (reset),
    .alu_res   (alu_res_if.arbiter),
    .mult_res  (mult_res_if.arbiter),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value)
  );

endmodule

//--- design/complete_arbiter.sv
// fixed priority, multiplier first; an ungranted alu result waits in its slot, the bus never stalls
module complete_arbiter import fu_pkg::*, cdb_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  // lane slots
  fu_result_if.arbiter alu_res,
  fu_result_if.arbiter mult_res,
  // common data bus
  output logic  cdb_valid,
  output tag_t  cdb_tag,
  output word_t cdb_value
);

  lane_t       sel_lane;
  cdb_result_t sel_result;
  // registered bus payload
  cdb_result_t cdb_q;
  logic        any_valid;

  //////////////////////////////
  // grant
  //////////////////////////////

  // multiplier wins any tie
  assign mult_res.grant = mult_res.valid;
  assign alu_res.grant  = alu_res.valid && !mult_res.valid;

  assign any_valid = alu_res.valid || mult_res.valid;
  assign sel_lane  = mult_res.valid ? lane_mult : lane_alu;

  // result of the granted lane
  always_comb begin
    case (sel_lane)
      lane_mult: sel_result = '{tag: mult_res.tag, value: mult_res.value};
      default:   sel_result = '{tag: alu_res.tag, value: alu_res.value};
    endcase
  end

  //////////////////////////////
  // bus register
  //////////////////////////////

  // one bus cycle per grant
  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= any_valid;
    end
  end

  // payload only loads on a grant
  always_ff @(posedge clock) begin
    if (any_valid) begin
      cdb_q <= sel_result;
    end
  end

  assign cdb_tag   = cdb_q.tag;
  assign cdb_value = cdb_q.value;

  //////////////////////////////
  // checks
  //////////////////////////////

  // at most one grant, never to an empty slot
  grant_legal: assert property (
    @(posedge clock) disable iff (reset)
    $onehot0({alu_res.grant, mult_res.grant})
      && (!alu_res.grant || alu_res.valid)
      && (!mult_res.grant || mult_res.valid)
  ) else $error("complete_arbiter: illegal grant pattern");

endmodule

//--- design/mult_lane.sv
// iterative multiplier, one operation in flight, low 64 product bits only; MULT_BITS must divide 64
module mult_lane import fu_pkg::*, cdb_pkg::*; #(
  // multiplier bits consumed per cycle
  parameter int MULT_BITS = mult_bits_default
) (
  input  logic  clock,
  input  logic  reset,
  // four-phase issue port
  input  logic  req,
  input  word_t a,
  input  word_t b,
  input  tag_t  tag,
  output logic  ack,
  // holding slot toward the arbiter
  fu_result_if.lane result
);

  // cycles per multiply
  localparam int num_steps = word_width / MULT_BITS;
  // counter needs at least one bit
  localparam int cnt_width = (num_steps > 1) ? $clog2(num_steps) : 1;
  localparam logic [cnt_width-1:0] last_step = cnt_width'(num_steps - 1);

  // elaboration guard on the step size
  if (word_width % MULT_BITS != 0) begin : g_bad_mult_bits
    $error("mult_lane: MULT_BITS must divide the word width");
  end

  logic                 busy;
  logic [cnt_width-1:0] step_cnt;
  // shifted multiplicand
  word_t                mcand;
  // multiplier bits not yet consumed
  word_t                mplier;
  // running low product
  word_t                acc;
  word_t                partial;
  word_t                next_acc;
  // tag waits here during the multiply
  tag_t                 tag_q;
  logic                 capture;
  logic                 last;

  //////////////////////////////
  // issue and step control
  //////////////////////////////

  // idle only when not busy, slot empty, ack low
  assign capture = req && !ack && !busy && !result.valid;
  // final step of the current multiply
  assign last    = busy && (step_cnt == last_step);

  // one MULT_BITS-wide digit per cycle, truncated to 64 bits
  assign partial  = mcand * word_t'(mplier[MULT_BITS-1:0]);
  assign next_acc = acc + partial;

  always_ff @(posedge clock) begin
    if (reset) begin
      ack          <= 1'b0;
      busy         <= 1'b0;
      step_cnt     <= '0;
      result.valid <= 1'b0;
    end else begin
      // four-phase ack
      if (capture) begin
        ack <= 1'b1;
      end else if (ack && !req) begin
        ack <= 1'b0;
      end
      // busy for exactly num_steps cycles
      if (capture) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (last) begin
        busy <= 1'b0;
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;
      end
      // done condition fills the slot
      if (last) begin
        result.valid <= 1'b1;
      end else if (result.grant) begin
        result.valid <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // shift-and-add datapath
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (capture) begin
      mcand  <= a;
      mplier <= b;
      acc    <= '0;
      tag_q  <= tag;
    end else if (busy) begin
      mcand  <= mcand << MULT_BITS;
      mplier <= mplier >> MULT_BITS;
      acc    <= next_acc;
    end
    // slot is always empty while busy, so no stall here
    if (last) begin
      result.value <= next_acc;
      result.tag   <= tag_q;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // a new operation only starts from a fully idle lane
  capture_when_idle: assert property (
    @(posedge clock) disable iff (reset)
    $rose(ack) |-> $past(!busy && !result.valid)
  ) else $error("mult_lane: operands captured while busy or slot full");

endmodule

//--- design/alu_lane.sv
// single-cycle alu; one held result at a time, a full slot withholds ack; unused opcodes run as add
module alu_lane import fu_pkg::*, cdb_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  // four-phase issue port
  input  logic    req,
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  input  tag_t    tag,
  output logic    ack,
  // holding slot toward the arbiter
  fu_result_if.lane result
);

  // combinational alu output
  word_t alu_out;
  // accept this edge
  logic  accept;

  //////////////////////////////
  // issue handshake
  //////////////////////////////

  // idle means slot empty and ack low
  // a full slot holds ack back, that is the back-pressure
  assign accept = req && !ack && !result.valid;

  //////////////////////////////
  // alu datapath
  //////////////////////////////

  always_comb begin
    case (op)
      alu_add:   alu_out = a + b;
      // wraps modulo 2^64
      alu_sub:   alu_out = a - b;
      alu_and:   alu_out = a & b;
      alu_or:    alu_out = a | b;
      alu_xor:   alu_out = a ^ b;
      // zero-extended compare flag
      alu_cmpeq: alu_out = word_t'(a == b);
      // codes 6 and 7
      default:   alu_out = a + b;
    endcase
  end

  //////////////////////////////
  // control state
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      ack          <= 1'b0;
      result.valid <= 1'b0;
    end else begin
      // ack rises on accept, falls on first req low
      if (accept) begin
        ack <= 1'b1;
      end else if (ack && !req) begin
        ack <= 1'b0;
      end
      // slot fills with ack, empties on grant
      if (accept) begin
        result.valid <= 1'b1;
      end else if (result.grant) begin
        result.valid <= 1'b0;
      end
    end
  end

  // result and tag captured at the ack-rising edge
  always_ff @(posedge clock) begin
    if (accept) begin
      result.tag   <= tag;
      result.value <= alu_out;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // ack only rises after req was seen high
  ack_follows_req: assert property (
    @(posedge clock) disable iff (reset)
    $rose(ack) |-> $past(req)
  ) else $error("alu_lane: ack rose while req was low");

  // held result does not move until the arbiter takes it
  held_result_stable: assert property (
    @(posedge clock) disable iff (reset)
    result.valid && !result.grant |=> $stable(result.tag) && $stable(result.value)
  ) else $error("alu_lane: held result changed before grant");

endmodule

//--- design/fu_result_if.sv
// grant may only be high while valid is high; the slot empties on the edge where grant is high
interface fu_result_if import fu_pkg::*, cdb_pkg::*; ();

  //////////////////////////////
  // held result
  //////////////////////////////

  // slot holds a finished result
  logic  valid;
  // destination physical register
  tag_t  tag;
  // result word
  word_t value;

  //////////////////////////////
  // completion grant
  //////////////////////////////

  // arbiter picks this slot this cycle
  logic  grant;

  // lane side owns the slot contents
  modport lane (
    output valid,
    output tag,
    output value,
    input  grant
  );

  // arbiter side only returns the grant
  modport arbiter (
    input  valid,
    input  tag,
    input  value,
    output grant
  );

endinterface

//--- design/cdb_pkg.sv
// result bus carries a 6-bit physical tag and one 64-bit word; only two lanes exist
package cdb_pkg;

  // word_t comes from the functional unit package
  import fu_pkg::*;

  //////////////////////////////
  // tags and lanes
  //////////////////////////////

  // physical register tag width
  localparam int tag_width = 6;

  typedef logic [tag_width-1:0] tag_t;

  // lane index, one bit for two lanes
  typedef enum logic [0:0] {
    lane_alu  = 1'b0,
    lane_mult = 1'b1
  } lane_t;

  //////////////////////////////
  // bus result
  //////////////////////////////

  // tag in the upper 6 bits, value below
  typedef struct packed {
    tag_t  tag;
    word_t value;
  } cdb_result_t;

endpackage

//--- design/fu_pkg.sv
// data word is fixed at 64 bits; only six alu operations are defined, other codes run as add
package fu_pkg;

  //////////////////////////////
  // data word
  //////////////////////////////

  // operand and result width
  localparam int word_width = 64;

  // one operand or one result
  typedef logic [word_width-1:0] word_t;

  //////////////////////////////
  // alu operations
  //////////////////////////////

  // 3-bit opcode, codes 6 and 7 unused
  typedef enum logic [2:0] {
    alu_add   = 3'd0,
    alu_sub   = 3'd1,
    alu_and   = 3'd2,
    alu_or    = 3'd3,
    alu_xor   = 3'd4,
    // 1 when equal, 0 otherwise
    alu_cmpeq = 3'd5
  } alu_op_t;

  //////////////////////////////
  // multiplier
  //////////////////////////////

  // multiplier bits retired per cycle
  // must divide word_width, 8 gives an 8-cycle multiply
  localparam int mult_bits_default = 8;

endpackage
